// ==== adc_trigger.f ====
+incdir+verification
hdl/adc_trigger_pkg.sv
hdl/baseline_calc.sv
hdl/pre_trigger_delay.sv
hdl/word_timer.sv
hdl/trigger_fsm.sv
hdl/entry_fifo.sv
hdl/beat_serializer.sv
hdl/adc_trigger_top.sv
verification/adc_trigger_tb.sv

// ==== hdl/adc_trigger_pkg.sv ====
package adc_trigger_pkg;

    // input stream geometry
    localparam int LANES    = 8;
    localparam int SAMPLE_W = 12;
    localparam int LANE_W   = 16;

    // output stream and header field widths
    localparam int OUT_W = 64;
    localparam int TS_W  = 32;
    localparam int EVT_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // lane 0 sits in the lowest bits, sample in the low bits of each lane
    typedef logic [LANES-1:0][LANE_W-1:0] adc_word_t;

    // one captured word, header fields only meaningful with first set
    typedef struct packed {
        adc_word_t        word;
        logic             first;
        logic             last;
        logic [TS_W-1:0]  timestamp;
        logic [EVT_W-1:0] event_num;
        sample_t          baseline;
    } frame_entry_t;

    typedef struct packed {
        logic [OUT_W-1:0] data;
        logic             user;
        logic             last;
    } out_beat_t;

endpackage

// ==== hdl/adc_trigger_top.sv ====
`timescale 1ns/1ns

module adc_trigger_top
    import adc_trigger_pkg::*;
#(
    parameter int PRE_LEN       = 4,
    parameter int POST_LEN      = 11,
    parameter int BASELINE_LOG2 = 4,
    parameter int THRESHOLD     = 40,
    parameter int FIFO_DEPTH    = 64
)
(
    input  logic                      axis_aclk,
    input  logic                      reset,
    input  logic [LANES*LANE_W-1:0]   s_axis_tdata,
    input  logic                      s_axis_tvalid,
    output logic                      s_axis_tready,
    output logic [OUT_W-1:0]          m_axis_tdata,
    output logic                      m_axis_tuser,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tvalid,
    input  logic                      m_axis_tready
);

    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

    adc_word_t          word;
    logic               word_valid;
    adc_word_t          delayed_word;
    sample_t            baseline;
    logic               baseline_done;
    logic [TS_W-1:0]    timestamp;
    logic               window_start;
    logic               window_active;
    logic               window_last;
    logic [FREE_W-1:0]  fifo_free;
    frame_entry_t       wr_entry;
    logic               wr_valid;
    frame_entry_t       rd_entry;
    logic               rd_valid;
    logic               rd_ready;
    out_beat_t          beat;

    // converter input never stalls once out of reset
    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            s_axis_tready <= 1'b0;
        end
        else
        begin
            s_axis_tready <= 1'b1;
        end
    end

    assign word       = s_axis_tdata;
    assign word_valid = s_axis_tvalid && s_axis_tready;

    baseline_calc #(
        .BASELINE_LOG2(BASELINE_LOG2)
    ) u_baseline_calc (
        .axis_aclk(axis_aclk), .reset(reset),
        .word(word), .word_valid(word_valid),
        .baseline(baseline), .baseline_done(baseline_done)
    );

    pre_trigger_delay #(
        .PRE_LEN(PRE_LEN)
    ) u_pre_trigger_delay (
        .axis_aclk(axis_aclk), .reset(reset),
        .word(word), .word_valid(word_valid),
        .delayed_word(delayed_word)
    );

    word_timer #(
        .PRE_LEN(PRE_LEN), .POST_LEN(POST_LEN)
    ) u_word_timer (
        .axis_aclk(axis_aclk), .reset(reset),
        .word_valid(word_valid), .window_start(window_start),
        .timestamp(timestamp), .window_active(window_active),
        .window_last(window_last)
    );

    trigger_fsm #(
        .PRE_LEN(PRE_LEN), .POST_LEN(POST_LEN),
        .THRESHOLD(THRESHOLD), .FIFO_DEPTH(FIFO_DEPTH)
    ) u_trigger_fsm (
        .axis_aclk(axis_aclk), .reset(reset),
        .word(word), .word_valid(word_valid), .delayed_word(delayed_word),
        .baseline(baseline), .baseline_done(baseline_done),
        .timestamp(timestamp), .window_active(window_active),
        .window_last(window_last), .fifo_free(fifo_free),
        .window_start(window_start), .entry(wr_entry), .entry_valid(wr_valid)
    );

    entry_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_entry_fifo (
        .axis_aclk(axis_aclk), .reset(reset),
        .wr_entry(wr_entry), .wr_valid(wr_valid),
        .rd_entry(rd_entry), .rd_valid(rd_valid), .rd_ready(rd_ready),
        .free_count(fifo_free)
    );

    beat_serializer u_beat_serializer (
        .axis_aclk(axis_aclk), .reset(reset),
        .entry(rd_entry), .entry_valid(rd_valid), .entry_ready(rd_ready),
        .beat(beat), .beat_valid(m_axis_tvalid), .beat_ready(m_axis_tready)
    );

    assign m_axis_tdata = beat.data;
    assign m_axis_tuser = beat.user;
    assign m_axis_tlast = beat.last;

endmodule

// ==== hdl/baseline_calc.sv ====
`timescale 1ns/1ns

module baseline_calc
    import adc_trigger_pkg::*;
#(
    parameter int BASELINE_LOG2 = 4
)
(
    input  logic      axis_aclk,
    input  logic      reset,
    input  adc_word_t word,
    input  logic      word_valid,
    output sample_t   baseline,
    output logic      baseline_done
);

    localparam int LANES_LOG2 = $clog2(LANES);
    localparam int SUM_W      = SAMPLE_W + LANES_LOG2;
    localparam int ACC_W      = SUM_W + BASELINE_LOG2;
    localparam int CAL_WORDS  = 1 << BASELINE_LOG2;

    logic [ACC_W-1:0]         acc;
    logic [BASELINE_LOG2:0]   cal_cnt;
    logic [SUM_W-1:0]         word_sum;

    // sum of the eight samples in one word
    always_comb
    begin
        word_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            word_sum = word_sum + SUM_W'(word[i][SAMPLE_W-1:0]);
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            acc           <= '0;
            cal_cnt       <= '0;
            baseline_done <= 1'b0;
        end
        else if (word_valid && !baseline_done)
        begin
            acc     <= acc + ACC_W'(word_sum);
            cal_cnt <= cal_cnt + 1'b1;
            if (cal_cnt == (BASELINE_LOG2 + 1)'(CAL_WORDS - 1))
            begin
                baseline_done <= 1'b1;
            end
        end
    end

    // mean over lanes and words is just the top bits of the sum
    assign baseline = acc[ACC_W-1 -: SAMPLE_W];

endmodule

// ==== hdl/beat_serializer.sv ====
`timescale 1ns/1ns

module beat_serializer
    import adc_trigger_pkg::*;
(
    input  logic         axis_aclk,
    input  logic         reset,
    input  frame_entry_t entry,
    input  logic         entry_valid,
    output logic         entry_ready,
    output out_beat_t    beat,
    output logic         beat_valid,
    input  logic         beat_ready
);

    localparam int WORD_W = LANES * LANE_W;
    localparam int PAD_W  = OUT_W - TS_W - EVT_W - SAMPLE_W;

    typedef enum logic [1:0] {ph_header, ph_low, ph_high} phase_t;

    frame_entry_t        cur;
    phase_t              phase;
    logic                busy;
    logic                beat_done;
    logic                last_beat;
    logic                take;
    logic [WORD_W-1:0]   word_bits;

    assign beat_done   = busy && beat_ready;
    assign last_beat   = beat_done && (phase == ph_high);
    assign entry_ready = !busy || last_beat;
    assign take        = entry_valid && entry_ready;

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            phase <= ph_low;
        end
        else if (take)
        begin
            busy  <= 1'b1;
            phase <= entry.first ? ph_header : ph_low;
        end
        else if (last_beat)
        begin
            busy <= 1'b0;
        end
        else if (beat_done)
        begin
            phase <= (phase == ph_header) ? ph_low : ph_high;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (take)
        begin
            cur <= entry;
        end
    end

    assign word_bits  = cur.word;
    assign beat_valid = busy;

    // beat built from held registers so it stays put under back-pressure
    always_comb
    begin
        case (phase)
            ph_header:
            begin
                beat.data = {cur.timestamp, cur.event_num, {PAD_W{1'b0}}, cur.baseline};
                beat.user = 1'b1;
                beat.last = 1'b0;
            end
            ph_low:
            begin
                beat.data = word_bits[OUT_W-1:0];
                beat.user = 1'b0;
                beat.last = 1'b0;
            end
            default:
            begin
                beat.data = word_bits[2*OUT_W-1:OUT_W];
                beat.user = 1'b0;
                beat.last = cur.last;
            end
        endcase
    end

endmodule

// ==== hdl/entry_fifo.sv ====
`timescale 1ns/1ns

module entry_fifo
    import adc_trigger_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  logic                            axis_aclk,
    input  logic                            reset,
    input  frame_entry_t                    wr_entry,
    input  logic                            wr_valid,
    output frame_entry_t                    rd_entry,
    output logic                            rd_valid,
    input  logic                            rd_ready,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] free_count
);

    localparam int AW     = $clog2(FIFO_DEPTH);
    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

    frame_entry_t       mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [FREE_W-1:0]  count;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = wr_valid && (count != FREE_W'(FIFO_DEPTH));
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // depth need not be a power of two, so pointers wrap explicitly
    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en)
            begin
                count <= count + 1'b1;
            end
            else if (rd_en && !wr_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

    assign rd_entry   = mem[rd_ptr];
    assign rd_valid   = (count != '0);
    assign free_count = FREE_W'(FIFO_DEPTH) - count;

endmodule

// ==== hdl/pre_trigger_delay.sv ====
`timescale 1ns/1ns

module pre_trigger_delay
    import adc_trigger_pkg::*;
#(
    parameter int PRE_LEN = 4
)
(
    input  logic      axis_aclk,
    input  logic      reset,
    input  adc_word_t word,
    input  logic      word_valid,
    output adc_word_t delayed_word
);

    // taps[0] holds the most recent accepted word
    adc_word_t taps [PRE_LEN];

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            for (int i = 0; i < PRE_LEN; i++)
            begin
                taps[i] <= '0;
            end
        end
        else if (word_valid)
        begin
            taps[0] <= word;
            for (int i = 1; i < PRE_LEN; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign delayed_word = taps[PRE_LEN-1];

endmodule

// ==== hdl/trigger_fsm.sv ====
`timescale 1ns/1ns

module trigger_fsm
    import adc_trigger_pkg::*;
#(
    parameter int PRE_LEN    = 4,
    parameter int POST_LEN   = 11,
    parameter int THRESHOLD  = 40,
    parameter int FIFO_DEPTH = 64
)
(
    input  logic                               axis_aclk,
    input  logic                               reset,
    input  adc_word_t                          word,
    input  logic                               word_valid,
    input  adc_word_t                          delayed_word,
    input  sample_t                            baseline,
    input  logic                               baseline_done,
    input  logic [TS_W-1:0]                    timestamp,
    input  logic                               window_active,
    input  logic                               window_last,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_free,
    output logic                               window_start,
    output frame_entry_t                       entry,
    output logic                               entry_valid
);

    localparam int FREE_W      = $clog2(FIFO_DEPTH + 1);
    localparam int FRAME_WORDS = PRE_LEN + POST_LEN + 1;

    typedef enum logic [1:0] {st_calibrate, st_armed, st_capture} state_t;

    state_t             state;
    logic [EVT_W-1:0]   event_cnt;
    logic               keep;
    logic [SAMPLE_W:0]  limit;
    logic               hit;
    logic               armed;
    logic               detect;
    logic [FREE_W-1:0]  free_now;
    logic               fits;

    assign limit = {1'b0, baseline} + (SAMPLE_W + 1)'(THRESHOLD);

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < LANES; i++)
        begin
            if ({1'b0, word[i][SAMPLE_W-1:0]} > limit)
            begin
                hit = 1'b1;
            end
        end
    end

    // first word after calibration may arrive before the state moves on
    assign armed  = (state == st_armed) || (state == st_calibrate && baseline_done);
    assign detect = word_valid && armed && hit;
    assign window_start = detect;

    // an entry still on its way into the fifo is already spoken for
    assign free_now = fifo_free - FREE_W'(entry_valid);
    assign fits     = (free_now >= FREE_W'(FRAME_WORDS));

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            state       <= st_calibrate;
            event_cnt   <= '0;
            keep        <= 1'b0;
            entry_valid <= 1'b0;
        end
        else
        begin
            entry_valid <= (detect && fits) ||
                           (state == st_capture && keep && word_valid && window_active);
            if (detect)
            begin
                state     <= st_capture;
                event_cnt <= event_cnt + 1'b1;
                keep      <= fits;
            end
            else
            begin
                case (state)
                    st_calibrate:
                    begin
                        if (baseline_done)
                        begin
                            state <= st_armed;
                        end
                    end
                    st_capture:
                    begin
                        if (word_valid && window_last)
                        begin
                            state <= st_armed;
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // entry payload, qualified by entry_valid
    always_ff @(posedge axis_aclk)
    begin
        if (word_valid)
        begin
            entry.word  <= delayed_word;
            entry.first <= detect;
            entry.last  <= (state == st_capture) && window_last;
        end
        if (detect)
        begin
            entry.timestamp <= timestamp;
            entry.event_num <= event_cnt;
            entry.baseline  <= baseline;
        end
    end

endmodule

// ==== hdl/word_timer.sv ====
`timescale 1ns/1ns

module word_timer
    import adc_trigger_pkg::*;
#(
    parameter int PRE_LEN  = 4,
    parameter int POST_LEN = 11
)
(
    input  logic            axis_aclk,
    input  logic            reset,
    input  logic            word_valid,
    input  logic            window_start,
    output logic [TS_W-1:0] timestamp,
    output logic            window_active,
    output logic            window_last
);

    // the delayed stream needs PRE_LEN extra words to drain the window
    localparam int WIN_LEN = PRE_LEN + POST_LEN;
    localparam int CNT_W   = $clog2(WIN_LEN + 1);

    logic [CNT_W-1:0] remaining;

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            timestamp <= '0;
        end
        else if (word_valid)
        begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (reset)
        begin
            remaining <= '0;
        end
        else if (window_start)
        begin
            remaining <= CNT_W'(WIN_LEN);
        end
        else if (word_valid && window_active)
        begin
            remaining <= remaining - 1'b1;
        end
    end

    assign window_active = (remaining != '0);
    assign window_last   = (remaining == CNT_W'(1));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator and run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module adc_trigger_tb -f adc_trigger.f -o adc_trigger_sim \
    && ./obj_dir/adc_trigger_sim 2>&1 | tee sim.log
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/adc_trigger_model.svh ====
`ifndef ADC_TRIGGER_MODEL_SVH
`define ADC_TRIGGER_MODEL_SVH

// accepted words in order, the index is the timestamp
adc_word_t model_words[$];
// kept detections still owed on the output
int        exp_ts[$];
int        exp_evt[$];
int        model_sum;
int        model_baseline;
int        model_event;
int        window_left;
bit        window_kept;
int        entries_made;
int        drops;

function automatic bit word_hits(input adc_word_t w);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < LANES; i++)
    begin
        if (int'(w[i][SAMPLE_W-1:0]) > model_baseline + THRESHOLD)
        begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

// completed and busy describe the output side just before the accepting edge
task automatic model_accept(input adc_word_t w, input int completed, input bit busy);
    int idx;
    int free_now;
    idx = model_words.size();
    model_words.push_back(w);
    if (idx < CAL_WORDS)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            model_sum += int'(w[i][SAMPLE_W-1:0]);
        end
        // mean over eight lanes and all calibration words
        if (idx == CAL_WORDS - 1)
        begin
            model_baseline = model_sum >> (3 + BASELINE_LOG2);
        end
    end
    else if (window_left > 0)
    begin
        window_left--;
        if (window_kept)
        begin
            entries_made++;
        end
    end
    else if (word_hits(w))
    begin
        // entries reserved minus entries already taken by the serializer
        free_now = FIFO_DEPTH - entries_made + completed + int'(busy);
        window_kept = (free_now >= FRAME_WORDS);
        if (window_kept)
        begin
            entries_made++;
            exp_ts.push_back(idx);
            exp_evt.push_back(model_event);
        end
        else
        begin
            drops++;
        end
        model_event++;
        // delayed stream needs PRE_LEN more words to drain
        window_left = PRE_LEN + POST_LEN;
    end
endtask

`endif

// ==== verification/adc_trigger_tb.sv ====
`timescale 1ns/1ns

module adc_trigger_tb
    import adc_trigger_pkg::*;
();

    localparam int PRE_LEN       = 2;
    localparam int POST_LEN      = 3;
    localparam int BASELINE_LOG2 = 3;
    localparam int THRESHOLD     = 40;
    localparam int FIFO_DEPTH    = 16;

    localparam int CAL_WORDS   = 1 << BASELINE_LOG2;
    localparam int FRAME_WORDS = PRE_LEN + POST_LEN + 1;
    localparam int FRAME_BEATS = 2 * FRAME_WORDS + 1;
    localparam int RUN_WORDS   = 1500;
    localparam int RUN_LIMIT   = 10000;
    localparam int CLOSE_LIMIT = 200;
    localparam int DRAIN_LIMIT = 3000;

    logic                    axis_aclk;
    logic                    reset;
    logic [LANES*LANE_W-1:0] s_axis_tdata;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic [OUT_W-1:0]        m_axis_tdata;
    logic                    m_axis_tuser;
    logic                    m_axis_tlast;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;

    logic [15:0] lfsr_state;
    int          ready_mode;
    int          phase_left;
    int          entries_completed;
    int          frames_seen;
    int          beat_idx;
    int          cycles;

    `include "adc_trigger_model.svh"

    adc_trigger_top #(
        .PRE_LEN(PRE_LEN), .POST_LEN(POST_LEN), .BASELINE_LOG2(BASELINE_LOG2),
        .THRESHOLD(THRESHOLD), .FIFO_DEPTH(FIFO_DEPTH)
    ) u_adc_trigger_top (
        .axis_aclk(axis_aclk), .reset(reset),
        .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .m_axis_tdata(m_axis_tdata), .m_axis_tuser(m_axis_tuser),
        .m_axis_tlast(m_axis_tlast), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever #2 axis_aclk = ~axis_aclk;
    end

    task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, got, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic stop_with_error(input string why);
        $display("at %0t ns: %s", $time, why);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // noise of 10 to 13 with junk in the unused top bits and sometimes one pulse
    function automatic adc_word_t make_word(input bit with_pulse);
        adc_word_t w;
        int        pulse_lane;
        pulse_lane = -1;
        if (with_pulse)
        begin
            if (random_bits(4) == 0)
            begin
                pulse_lane = int'(random_bits(3));
            end
        end
        for (int i = 0; i < LANES; i++)
        begin
            w[i][LANE_W-1:SAMPLE_W] = 4'(random_bits(4));
            if (i == pulse_lane)
            begin
                w[i][SAMPLE_W-1:0] = 12'(20 + random_bits(7));
            end
            else
            begin
                w[i][SAMPLE_W-1:0] = 12'(10 + random_bits(2));
            end
        end
        return w;
    endfunction

    // phases of ready high, random ready and long stalls
    task automatic next_ready();
        if (phase_left == 0)
        begin
            ready_mode = int'(random_bits(2));
            phase_left = (ready_mode == 3) ? 40 + int'(random_bits(6))
                                           : 16 + int'(random_bits(6));
        end
        phase_left--;
        if (ready_mode == 3)
        begin
            m_axis_tready = 1'b0;
        end
        else if (ready_mode == 2)
        begin
            m_axis_tready = random_bits(1) != 0;
        end
        else
        begin
            m_axis_tready = 1'b1;
        end
    endtask

    // monitor for one transferred beat
    task automatic collect_beat();
        logic [LANES*LANE_W-1:0] flat;
        logic [63:0]             exp_data;
        logic                    exp_user;
        logic                    exp_last;
        int                      k;
        if (exp_ts.size() == 0)
        begin
            stop_with_error("output beat arrived with no frame expected");
        end
        if (beat_idx == 0)
        begin
            exp_data = {32'(exp_ts[0]), 16'(exp_evt[0]), 16'(model_baseline)};
            exp_user = 1'b1;
            exp_last = 1'b0;
        end
        else
        begin
            k = (beat_idx - 1) / 2;
            flat = model_words[exp_ts[0] - PRE_LEN + k];
            exp_data = (beat_idx % 2 == 1) ? flat[63:0] : flat[127:64];
            exp_user = 1'b0;
            exp_last = (beat_idx == FRAME_BEATS - 1);
        end
        check_equal(m_axis_tdata, exp_data,
                    $sformatf("event %0d beat %0d tdata", exp_evt[0], beat_idx));
        check_equal(64'(m_axis_tuser), 64'(exp_user),
                    $sformatf("event %0d beat %0d tuser", exp_evt[0], beat_idx));
        check_equal(64'(m_axis_tlast), 64'(exp_last),
                    $sformatf("event %0d beat %0d tlast", exp_evt[0], beat_idx));
        if (beat_idx > 0 && beat_idx % 2 == 0)
        begin
            entries_completed++;
        end
        if (beat_idx == FRAME_BEATS - 1)
        begin
            beat_idx = 0;
            frames_seen++;
            void'(exp_ts.pop_front());
            void'(exp_evt.pop_front());
        end
        else
        begin
            beat_idx++;
        end
    endtask

    // outputs sampled here hold until the coming edge
    task automatic run_cycle(input bit with_pulses, input bit draining);
        adc_word_t w;
        logic      in_valid;
        @(posedge axis_aclk);
        #1;
        check_equal(64'(s_axis_tready), 64'(1), "s_axis_tready out of reset");
        if (model_words.size() == 0)
        begin
            check_equal(64'(m_axis_tvalid), 64'(0), "m_axis_tvalid before first word");
        end
        next_ready();
        in_valid = random_bits(2) != 0;
        w = make_word(with_pulses);
        if (draining)
        begin
            in_valid = 1'b0;
            m_axis_tready = 1'b1;
        end
        s_axis_tvalid = in_valid;
        s_axis_tdata = w;
        if (in_valid && s_axis_tready)
        begin
            model_accept(w, entries_completed, m_axis_tvalid);
        end
        if (m_axis_tvalid && m_axis_tready)
        begin
            collect_beat();
        end
    endtask

    initial
    begin
        lfsr_state = 16'd47;
        reset = 1'b1;
        s_axis_tvalid = 1'b0;
        s_axis_tdata = '0;
        m_axis_tready = 1'b0;
        ready_mode = 0;
        phase_left = 200;
        entries_completed = 0;
        frames_seen = 0;
        beat_idx = 0;
        repeat (5)
        begin
            @(posedge axis_aclk);
            #1;
            check_equal(64'(s_axis_tready), 64'(0), "s_axis_tready in reset");
            check_equal(64'(m_axis_tvalid), 64'(0), "m_axis_tvalid in reset");
        end
        reset = 1'b0;
        #1;
        check_equal(64'(s_axis_tready), 64'(0), "s_axis_tready in the cycle after reset");

        cycles = 0;
        while (model_words.size() < RUN_WORDS)
        begin
            run_cycle(1'b1, 1'b0);
            cycles++;
            if (cycles > RUN_LIMIT)
            begin
                stop_with_error("input words were not accepted in time");
            end
        end

        // quiet words until the last window has closed
        cycles = 0;
        while (window_left > 0)
        begin
            run_cycle(1'b0, 1'b0);
            cycles++;
            if (cycles > CLOSE_LIMIT)
            begin
                stop_with_error("last capture window did not close");
            end
        end

        cycles = 0;
        while (exp_ts.size() > 0)
        begin
            run_cycle(1'b0, 1'b1);
            cycles++;
            if (cycles > DRAIN_LIMIT)
            begin
                stop_with_error("expected frames did not arrive on the output");
            end
        end

        // nothing more may come out
        repeat (20)
        begin
            run_cycle(1'b0, 1'b1);
        end

        if (frames_seen == 0)
        begin
            stop_with_error("no frame was delivered during the run");
        end
        else
        begin
            $display("%0d frames delivered, %0d of %0d detections dropped",
                     frames_seen, drops, model_event);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
